// File: Makefile
TOP := tb_exec_pipeline
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: design/alu_flags.sv
// ALU and condition flags
`default_nettype none

`include "arm_cfg.svh"

module alu_flags (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid,
  input  arm_isa_pkg::alu_op_e op,
  input  logic                 set_flags,
  input  arm_dp_pkg::word_t    a,
  input  arm_dp_pkg::word_t    b,
  output arm_dp_pkg::word_t    result,
  output arm_dp_pkg::flags_t   flags
);

  localparam int MSB = `ARM_WORD_W - 1;

  logic [`ARM_WORD_W:0] sum_ext;  // Extra bit holds carry out
  arm_dp_pkg::word_t    diff;
  arm_dp_pkg::flags_t   next_flags;

  assign sum_ext = {1'b0, a} + {1'b0, b};
  assign diff    = a - b;

  always_comb begin
    case (op)
      arm_isa_pkg::op_and: result = a & b;
      arm_isa_pkg::op_orr: result = a | b;
      arm_isa_pkg::op_sub: result = diff;
      arm_isa_pkg::op_add: result = sum_ext[MSB:0];
      arm_isa_pkg::op_mov: result = b;
      default:             result = '0;
    endcase
  end

  always_comb begin
    next_flags.n = result[MSB];
    next_flags.z = (result == '0);
    next_flags.c = flags.c;  // Logic ops keep C and V
    next_flags.v = flags.v;
    case (op)
      arm_isa_pkg::op_add: begin
        next_flags.c = sum_ext[`ARM_WORD_W];
        next_flags.v = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
      end
      arm_isa_pkg::op_sub: begin
        next_flags.c = (a >= b);  // No borrow
        next_flags.v = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (valid && set_flags) begin
      flags <= next_flags;
    end
  end

  op_known: assert property (
    @(posedge clk) disable iff (reset) valid |-> !$isunknown(op)
  ) else $error("alu_flags: unknown opcode in execute");

endmodule

`default_nettype wire

// File: design/arm_cfg.svh
// Execute core configuration
`ifndef ARM_CFG_SVH
`define ARM_CFG_SVH

// Datapath width in bits
`define ARM_WORD_W 32

`define ARM_REG_COUNT 16  // General registers
`define ARM_REG_IDX_W 4   // Bits to address one register

// Immediate rotate field counts in steps of two bits
`define ARM_ROT_SCALE 2

`endif

// File: design/arm_dp_pkg.sv
// Datapath type definitions
`default_nettype none

`include "arm_cfg.svh"

package arm_dp_pkg;

  typedef logic [`ARM_WORD_W-1:0] word_t;

  typedef logic [`ARM_REG_IDX_W-1:0] reg_idx_t;

  // Condition flags in NZCV order
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef enum logic [1:0] {
    fwd_reg,  // Register file value
    fwd_ex,   // Result still in execute
    fwd_wb    // Result waiting for write-back
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: design/arm_isa_pkg.sv
// Instruction set definitions
`default_nettype none

`include "arm_cfg.svh"

package arm_isa_pkg;

  typedef enum logic [3:0] {
    op_and = 4'd0,
    op_orr = 4'd1,
    op_sub = 4'd2,
    op_add = 4'd3,
    op_mov = 4'd4  // Remaining codes produce zero
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_lsl,
    sh_lsr,
    sh_asr,
    sh_ror
  } shift_e;

  // Data-processing word, MSB first
  typedef struct packed {
    logic [5:0]                unused;
    logic                      imm;
    alu_op_e                   opcode;
    logic                      set_flags;
    logic [`ARM_REG_IDX_W-1:0] rn;
    logic [`ARM_REG_IDX_W-1:0] rd;
    logic [11:0]               operand;
  } instr_t;

  typedef struct packed {
    logic [3:0] rot;   // Rotate right by scale times this
    logic [7:0] imm8;
  } imm_operand_t;

  typedef struct packed {
    logic [4:0]                amount;
    shift_e                    kind;
    logic                      unused;
    logic [`ARM_REG_IDX_W-1:0] rm;
  } reg_operand_t;

endpackage

`default_nettype wire

// File: design/exec_pipeline.sv
// Three-stage execute pipeline
`default_nettype none

module exec_pipeline (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 instr_valid,
  input  arm_isa_pkg::instr_t  instr,
  output logic                 wb_valid,
  output arm_dp_pkg::reg_idx_t wb_rd,
  output arm_dp_pkg::word_t    wb_data,
  output arm_dp_pkg::flags_t   flags
);

  // Decode fields
  arm_isa_pkg::reg_operand_t id_reg_fields;
  arm_dp_pkg::reg_idx_t      id_rn;
  arm_dp_pkg::reg_idx_t      id_rm;
  arm_dp_pkg::word_t         rf_rdata_a;
  arm_dp_pkg::word_t         rf_rdata_b;
  arm_dp_pkg::word_t         rn_value;
  arm_dp_pkg::word_t         rm_value;

  // ID/EX stage
  logic                 ex_valid;
  arm_isa_pkg::alu_op_e ex_op;
  logic                 ex_set_flags;
  arm_dp_pkg::reg_idx_t ex_rd;
  arm_dp_pkg::word_t    ex_rn_value;
  logic                 ex_imm;
  logic [11:0]          ex_operand;
  arm_dp_pkg::word_t    ex_rm_value;

  arm_dp_pkg::word_t    ex_op2;
  arm_dp_pkg::word_t    ex_result;

  assign id_reg_fields = arm_isa_pkg::reg_operand_t'(instr.operand);
  assign id_rn         = instr.rn;
  assign id_rm         = id_reg_fields.rm;  // Ignored later for immediates

  // Written from the EX/WB stage
  register_file u_regs (
    .clk     (clk),
    .reset   (reset),
    .we      (wb_valid),
    .waddr   (wb_rd),
    .wdata   (wb_data),
    .raddr_a (id_rn),
    .raddr_b (id_rm),
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b)
  );

  operand_forward u_fwd_rn (
    .src       (id_rn),
    .reg_value (rf_rdata_a),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_value  (ex_result),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_value  (wb_data),
    .value     (rn_value)
  );

  operand_forward u_fwd_rm (
    .src       (id_rm),
    .reg_value (rf_rdata_b),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_value  (ex_result),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_value  (wb_data),
    .value     (rm_value)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= instr_valid;
    end
  end

  // Payload of the ID/EX stage
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      ex_op        <= instr.opcode;
      ex_set_flags <= instr.set_flags;
      ex_rd        <= instr.rd;
      ex_rn_value  <= rn_value;
      ex_imm       <= instr.imm;
      ex_operand   <= instr.operand;
      ex_rm_value  <= rm_value;
    end
  end

  operand_shifter u_shifter (
    .imm      (ex_imm),
    .operand  (ex_operand),
    .rm_value (ex_rm_value),
    .op2      (ex_op2)
  );

  // Flags land together with the write-back strobe
  alu_flags u_alu (
    .clk       (clk),
    .reset     (reset),
    .valid     (ex_valid),
    .op        (ex_op),
    .set_flags (ex_set_flags),
    .a         (ex_rn_value),
    .b         (ex_op2),
    .result    (ex_result),
    .flags     (flags)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      wb_rd   <= ex_rd;
      wb_data <= ex_result;
    end
  end

endmodule

`default_nettype wire

// File: design/operand_forward.sv
// Source operand bypass select
`default_nettype none

module operand_forward (
  input  arm_dp_pkg::reg_idx_t src,
  input  arm_dp_pkg::word_t    reg_value,
  input  logic                 ex_valid,
  input  arm_dp_pkg::reg_idx_t ex_rd,
  input  arm_dp_pkg::word_t    ex_value,
  input  logic                 wb_valid,
  input  arm_dp_pkg::reg_idx_t wb_rd,
  input  arm_dp_pkg::word_t    wb_value,
  output arm_dp_pkg::word_t    value
);

  arm_dp_pkg::fwd_sel_e sel;

  // Newest producer wins
  always_comb begin
    if (ex_valid && (ex_rd == src)) begin
      sel = arm_dp_pkg::fwd_ex;
    end else if (wb_valid && (wb_rd == src)) begin
      sel = arm_dp_pkg::fwd_wb;
    end else begin
      sel = arm_dp_pkg::fwd_reg;
    end
  end

  always_comb begin
    case (sel)
      arm_dp_pkg::fwd_ex: value = ex_value;
      arm_dp_pkg::fwd_wb: value = wb_value;
      default:            value = reg_value;
    endcase
  end

endmodule

`default_nettype wire

// File: design/operand_shifter.sv
// Second operand builder
`default_nettype none

`include "arm_cfg.svh"

module operand_shifter (
  input  logic              imm,
  input  logic [11:0]       operand,
  input  arm_dp_pkg::word_t rm_value,
  output arm_dp_pkg::word_t op2
);

  arm_isa_pkg::imm_operand_t imm_fields;
  arm_isa_pkg::reg_operand_t reg_fields;
  logic [4:0]                rot_amt;
  arm_dp_pkg::word_t         imm_ext;
  logic [2*`ARM_WORD_W-1:0]  imm_pair;
  logic [2*`ARM_WORD_W-1:0]  rm_pair;

  assign imm_fields = arm_isa_pkg::imm_operand_t'(operand);
  assign reg_fields = arm_isa_pkg::reg_operand_t'(operand);

  assign rot_amt = 5'(`ARM_ROT_SCALE * imm_fields.rot);
  assign imm_ext = arm_dp_pkg::word_t'(imm_fields.imm8);  // Zero extended

  // Rotations as a shift of the doubled word
  assign imm_pair = {imm_ext, imm_ext} >> rot_amt;
  assign rm_pair  = {rm_value, rm_value} >> reg_fields.amount;

  // Zero amount leaves rm_value as is for every kind
  always_comb begin
    if (imm) begin
      op2 = imm_pair[`ARM_WORD_W-1:0];
    end else begin
      case (reg_fields.kind)
        arm_isa_pkg::sh_lsl: op2 = rm_value << reg_fields.amount;
        arm_isa_pkg::sh_lsr: op2 = rm_value >> reg_fields.amount;
        arm_isa_pkg::sh_asr: begin
          op2 = arm_dp_pkg::word_t'($signed(rm_value) >>> reg_fields.amount);
        end
        arm_isa_pkg::sh_ror: op2 = rm_pair[`ARM_WORD_W-1:0];
        default:             op2 = rm_value;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/register_file.sv
// General register file
`default_nettype none

`include "arm_cfg.svh"

module register_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 we,
  input  arm_dp_pkg::reg_idx_t waddr,
  input  arm_dp_pkg::word_t    wdata,
  input  arm_dp_pkg::reg_idx_t raddr_a,
  input  arm_dp_pkg::reg_idx_t raddr_b,
  output arm_dp_pkg::word_t    rdata_a,
  output arm_dp_pkg::word_t    rdata_b
);

  arm_dp_pkg::word_t regs [`ARM_REG_COUNT];

  // Single write port, all registers start at zero
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `ARM_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Plain reads, same-cycle writes are bypassed outside
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

  // An X index would corrupt the whole file
  waddr_known: assert property (
    @(posedge clk) disable iff (reset) we |-> !$isunknown(waddr)
  ) else $error("register_file: write with unknown address");

endmodule

`default_nettype wire

// File: verif/clk_gen.sv
// Clock and reset source
`default_nettype none

module clk_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 2;   // 4 ns clock
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;  // Released on a rising edge
  end

endmodule

`default_nettype wire

// File: verif/tb_exec_pipeline.sv
// Execute pipeline testbench
`default_nettype none

`include "arm_cfg.svh"

module tb_exec_pipeline;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_INSTR   = 400;
  localparam int MAX_GAP     = 3;
  localparam int CYCLE_LIMIT = NUM_INSTR * (MAX_GAP + 1) + 100;

  logic                 clk;
  logic                 reset;
  logic                 instr_valid;
  arm_isa_pkg::instr_t  instr;
  logic                 wb_valid;
  arm_dp_pkg::reg_idx_t wb_rd;
  arm_dp_pkg::word_t    wb_data;
  arm_dp_pkg::flags_t   flags;

  integer seed;
  int     cycle;
  int     errors;
  int     checks;
  int     wb_count;
  logic   wb_seen;
  logic [3:0] rot_next;                   // Steps through every rotate value
  logic [3:0] prev_rd [2];                // Destinations of the last two issues

  arm_dp_pkg::word_t model_regs [`ARM_REG_COUNT];
  logic [3:0]        model_flags;         // NZCV
  logic [3:0]        exp_rd_q [$];
  arm_dp_pkg::word_t exp_data_q [$];
  logic [3:0]        exp_flags_q [$];
  int                issue_q [$];

  clk_gen clk_gen0 (
    .clk   (clk),
    .reset (reset)
  );

  exec_pipeline dut0 (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .flags       (flags)
  );

  task automatic check_value(input arm_dp_pkg::word_t actual, input arm_dp_pkg::word_t expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // One bit position per step
  function automatic arm_dp_pkg::word_t rotate_right(input arm_dp_pkg::word_t v, input int amt);
    arm_dp_pkg::word_t r;
    int                i;
    r = v;
    for (i = 0; i < amt; i++) begin
      r = {r[0], r[31:1]};
    end
    return r;
  endfunction

  function automatic arm_dp_pkg::word_t shift_value(input arm_dp_pkg::word_t v,
                                                    input logic [1:0] kind, input int amt);
    arm_dp_pkg::word_t r;
    int                i;
    r = v;
    case (kind)
      arm_isa_pkg::sh_lsl: r = v << amt;
      arm_isa_pkg::sh_lsr: r = v >> amt;
      arm_isa_pkg::sh_asr: begin
        for (i = 0; i < amt; i++) begin
          r = {r[31], r[31:1]};   // Sign bit refills
        end
      end
      default: r = rotate_right(v, amt);
    endcase
    return r;
  endfunction

  function automatic arm_dp_pkg::word_t alu_result(input logic [3:0] op,
                                                   input arm_dp_pkg::word_t a,
                                                   input arm_dp_pkg::word_t b);
    case (op)
      arm_isa_pkg::op_and: return a & b;
      arm_isa_pkg::op_orr: return a | b;
      arm_isa_pkg::op_sub: return a - b;
      arm_isa_pkg::op_add: return a + b;
      arm_isa_pkg::op_mov: return b;
      default:             return '0;
    endcase
  endfunction

  // Program-order model applied at issue time
  task automatic apply_model(input logic [31:0] word);
    logic [3:0]        op;
    arm_dp_pkg::word_t a;
    arm_dp_pkg::word_t b;
    arm_dp_pkg::word_t res;
    logic              c;
    logic              v;
    op = word[24:21];
    a  = model_regs[word[19:16]];
    if (word[25]) begin
      b = rotate_right({24'b0, word[7:0]}, `ARM_ROT_SCALE * int'(word[11:8]));
    end else begin
      b = shift_value(model_regs[word[3:0]], word[6:5], int'(word[11:7]));
    end
    res = alu_result(op, a, b);
    c   = model_flags[1];
    v   = model_flags[0];
    if (op == arm_isa_pkg::op_add) begin
      c = (res < a);                      // Wrapped past 2**32
      v = (a[31] == b[31]) && (res[31] != a[31]);
    end else if (op == arm_isa_pkg::op_sub) begin
      c = (a >= b);
      v = (a[31] != b[31]) && (res[31] != a[31]);
    end
    if (word[20]) begin
      model_flags = {res[31], (res == 0), c, v};
    end
    model_regs[word[15:12]] = res;
    exp_rd_q.push_back(word[15:12]);
    exp_data_q.push_back(res);
    exp_flags_q.push_back(model_flags);
  endtask

  task automatic build_instr(output logic [31:0] word);
    logic [31:0] rnd;
    logic [31:0] fields;
    logic [3:0]  op;
    logic [3:0]  rn;
    logic [3:0]  rm;
    logic [3:0]  rd;
    rnd    = $random(seed);
    fields = $random(seed);
    rd     = fields[3:0];
    rn     = fields[7:4];
    rm     = fields[11:8];
    if (fields[15:12] < 4'd5) begin       // Roughly a third lean on recent results
      rn = prev_rd[fields[16]];
      rm = prev_rd[fields[17]];
    end
    op = (fields[31:29] == 3'd0) ? rnd[24:21] : {1'b0, rnd[23:21] % 3'd5};
    word        = rnd;                    // Unused bits stay random
    word[25]    = fields[18];
    word[24:21] = op;
    word[20]    = fields[19];
    word[19:16] = rn;
    word[15:12] = rd;
    if (fields[18]) begin
      word[11:8] = rot_next;
      rot_next   = rot_next + 4'd1;
    end else begin
      word[11:7] = (fields[21:20] == 2'd0) ? 5'd0 : fields[26:22];
      word[6:5]  = fields[28:27];
      word[3:0]  = rm;
    end
    prev_rd[1] = prev_rd[0];
    prev_rd[0] = rd;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Samples before this edge's updates land
  always @(posedge clk) begin
    int issue;
    if (reset) begin
      check_value({31'b0, wb_valid}, 32'd0, "wb_valid during reset");
      check_value({28'b0, flags}, 32'd0, "flags during reset");
    end else begin
      if (instr_valid) begin
        issue_q.push_back(cycle);
      end
      if (wb_valid) begin
        wb_count++;
        wb_seen = 1'b1;
        if (issue_q.size() == 0) begin
          errors++;
          $display("Write-back strobe at %0t ns with no instruction outstanding", $time);
        end else begin
          issue = issue_q.pop_front();
          check_value(arm_dp_pkg::word_t'(cycle - issue), 32'd2, "write-back latency");
          check_value({28'b0, wb_rd}, {28'b0, exp_rd_q.pop_front()}, "wb_rd");
          check_value(wb_data, exp_data_q.pop_front(), "wb_data");
          check_value({28'b0, flags}, {28'b0, exp_flags_q.pop_front()}, "flags");
        end
      end else if (!wb_seen) begin
        check_value({28'b0, flags}, 32'd0, "flags before first write-back");
      end
    end
  end

  initial begin
    while (cycle < CYCLE_LIMIT) @(posedge clk);
    $display("The run timed out after %0d cycles before all results came back", cycle);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] word;
    logic [31:0] rnd;
    int          gap;
    int          n;
    seed        = 32'hd1b6_4031;
    cycle       = 0;
    errors      = 0;
    checks      = 0;
    wb_count    = 0;
    wb_seen     = 1'b0;
    rot_next    = 4'd0;
    prev_rd[0]  = 4'd0;
    prev_rd[1]  = 4'd0;
    model_flags = 4'd0;
    instr_valid = 1'b0;
    instr       = '0;
    for (n = 0; n < `ARM_REG_COUNT; n++) begin
      model_regs[n] = '0;
    end
    @(posedge clk);
    wait (!reset);
    @(posedge clk);
    for (n = 0; n < NUM_INSTR; n++) begin
      build_instr(word);
      apply_model(word);
      instr       <= arm_isa_pkg::instr_t'(word);
      instr_valid <= 1'b1;
      @(posedge clk);
      rnd = $random(seed);
      gap = int'(rnd[1:0]);
      if (gap > 0) begin
        instr_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    instr_valid <= 1'b0;
    while (exp_data_q.size() != 0) @(posedge clk);
    repeat (2) @(negedge clk);            // Room for a stray strobe
    check_value(arm_dp_pkg::word_t'(wb_count), arm_dp_pkg::word_t'(NUM_INSTR), "write-back count");
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/arm_isa_pkg.sv
design/arm_dp_pkg.sv
design/register_file.sv
design/operand_forward.sv
design/operand_shifter.sv
design/alu_flags.sv
design/exec_pipeline.sv
verif/clk_gen.sv
verif/tb_exec_pipeline.sv
